//--- include/bpred_cfg.svh
`ifndef BPRED_CFG_SVH
`define BPRED_CFG_SVH

// Halfword PC width
`define BP_PC_W 31

// Offset inside a fetch block of four halfwords
`define BP_OFF_W 2

// Fetch ID width, one backup entry per ID
`define BP_FID_W 3

// Global history length
`define BP_HIST_W 6

// Table sizes as index widths
`define BP_BTB_IDX_W 4
`define BP_PHT_IDX_W 6
`define BP_RAS_IDX_W 2

// Pending commit updates
`define BP_UPDQ_DEPTH 4

// Reset fetch address in halfwords
`define BP_ENTRY_POINT 31'h100

`endif

//--- logic/bpredPkg.sv
`default_nettype none

`include "bpred_cfg.svh"

package bpredPkg;

    typedef enum logic [1:0] {
        BT_BRANCH,
        BT_JUMP,
        BT_CALL,
        BT_RETURN
    } BranchType;

    // Return stack adjustment carried by a mispredict
    typedef enum logic [1:0] {
        RET_NONE,
        RET_PUSH,
        RET_POP
    } RetAction;

    // First predicted branch of a fetch block
    typedef struct packed {
        logic                  valid;
        BranchType             btype;
        logic                  taken;
        logic [`BP_OFF_W-1:0]  offs;
        logic [`BP_PC_W-1:0]   dst;
    } PredBranch;

    // Snapshot taken at fetch, read back for recovery and training
    typedef struct packed {
        logic [`BP_PC_W-1:0]       fetchPc;
        logic [`BP_HIST_W-1:0]     history;
        logic [`BP_RAS_IDX_W-1:0]  rIdx;
        logic                      pred;
        logic                      predTaken;
        logic [`BP_OFF_W-1:0]      predOffs;
    } BpBackup;

endpackage

`default_nettype wire

//--- logic/bpredIfs.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

// Branch target write from the execute side
interface btbUpdateIf;
    logic                 valid;
    logic [`BP_PC_W-1:0]  pc;
    logic [`BP_PC_W-1:0]  dst;
    bpredPkg::BranchType  btype;

    modport source (output valid, output pc, output dst, output btype);
    modport target (input valid, input pc, input dst, input btype);
endinterface

// Counter training from the commit update stage
interface dirUpdateIf;
    logic                   valid;
    logic [`BP_PC_W-1:0]    pc;
    logic [`BP_HIST_W-1:0]  history;
    logic                   taken;

    modport source (output valid, output pc, output history, output taken);
    modport target (input valid, input pc, input history, input taken);
endinterface

`default_nettype wire

//--- logic/branchTargetBuffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module branchTargetBuffer (
    input  wire                   clk,
    input  wire                   rst,
    input  wire [`BP_PC_W-1:0]    pc,
    btbUpdateIf.target            upd,
    output bpredPkg::PredBranch   hit
);

    localparam int ENTRIES = 1 << `BP_BTB_IDX_W;
    localparam int TAG_W = `BP_PC_W - `BP_OFF_W - `BP_BTB_IDX_W;

    logic [ENTRIES-1:0]      entryValid;
    logic [TAG_W-1:0]        tagMem   [ENTRIES];
    logic [`BP_OFF_W-1:0]    offsMem  [ENTRIES];
    bpredPkg::BranchType     btypeMem [ENTRIES];
    logic [`BP_PC_W-1:0]     dstMem   [ENTRIES];

    logic [`BP_BTB_IDX_W-1:0] rdIdx;
    logic [TAG_W-1:0]         rdTag;
    logic [`BP_BTB_IDX_W-1:0] wrIdx;
    logic [TAG_W-1:0]         wrTag;

    // Block bits select the entry, the bits above them form the tag
    assign rdIdx = pc[`BP_OFF_W +: `BP_BTB_IDX_W];
    assign rdTag = pc[`BP_PC_W-1 -: TAG_W];
    assign wrIdx = upd.pc[`BP_OFF_W +: `BP_BTB_IDX_W];
    assign wrTag = upd.pc[`BP_PC_W-1 -: TAG_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            entryValid <= '0;
        end else if (upd.valid) begin
            entryValid[wrIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (upd.valid) begin
            tagMem[wrIdx]   <= wrTag;
            offsMem[wrIdx]  <= upd.pc[`BP_OFF_W-1:0];
            btypeMem[wrIdx] <= upd.btype;
            dstMem[wrIdx]   <= upd.dst;
        end
    end

    // A branch before the fetch offset is behind us and does not count
    always_comb begin
        hit = '0;
        hit.btype = bpredPkg::BT_BRANCH;
        if (entryValid[rdIdx] && tagMem[rdIdx] == rdTag
                && offsMem[rdIdx] >= pc[`BP_OFF_W-1:0]) begin
            hit.valid = 1'b1;
            hit.btype = btypeMem[rdIdx];
            hit.taken = (btypeMem[rdIdx] != bpredPkg::BT_BRANCH);
            hit.offs  = offsMem[rdIdx];
            hit.dst   = dstMem[rdIdx];
        end
    end

    // Execute must always resolve the branch type before writing
    updTypeKnown: assert property (
        @(posedge clk) disable iff (rst)
        upd.valid |-> !$isunknown(upd.btype)
    );

endmodule

`default_nettype wire

//--- logic/directionPredictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module directionPredictor (
    input  wire                    clk,
    input  wire                    rst,
    input  wire [`BP_PC_W-1:0]     pc,
    input  wire [`BP_HIST_W-1:0]   history,
    output logic                   taken,
    dirUpdateIf.target             upd
);

    localparam int COUNTERS = 1 << `BP_PHT_IDX_W;

    logic [1:0] pht [COUNTERS];

    logic [`BP_PHT_IDX_W-1:0] rdIdx;
    logic [`BP_PHT_IDX_W-1:0] wrIdx;
    logic [1:0]               wrCtr;

    // gshare index, block bits folded with global history
    assign rdIdx = pc[`BP_OFF_W +: `BP_PHT_IDX_W] ^ history;
    assign wrIdx = upd.pc[`BP_OFF_W +: `BP_PHT_IDX_W] ^ upd.history;

    // Upper counter bit is the direction
    assign taken = pht[rdIdx][1];

    assign wrCtr = pht[wrIdx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // Weakly not-taken
            for (int i = 0; i < COUNTERS; i++) begin
                pht[i] <= 2'b01;
            end
        end else if (upd.valid) begin
            if (upd.taken && wrCtr != 2'b11) begin
                pht[wrIdx] <= wrCtr + 2'b01;
            end else if (!upd.taken && wrCtr != 2'b00) begin
                pht[wrIdx] <= wrCtr - 2'b01;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/returnStack.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module returnStack (
    input  wire                       clk,
    input  wire                       rst,
    input  wire                       push,
    input  wire                       pop,
    input  wire [`BP_PC_W-1:0]        pushAddr,
    input  wire                       restore,
    input  wire [`BP_RAS_IDX_W-1:0]   restoreIdx,
    output logic [`BP_PC_W-1:0]       topAddr,
    output logic [`BP_RAS_IDX_W-1:0]  idx
);

    localparam int DEPTH = 1 << `BP_RAS_IDX_W;

    logic [`BP_PC_W-1:0]      stack [DEPTH];
    logic [`BP_RAS_IDX_W-1:0] pushSlot;

    // Wraps around, oldest return gets overwritten
    assign pushSlot = idx + 1'b1;
    assign topAddr = stack[idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            idx <= '0;
        end else if (restore) begin
            idx <= restoreIdx;
        end else if (push) begin
            idx <= pushSlot;
        end else if (pop) begin
            idx <= idx - 1'b1;
        end
    end

    // Slots are not cleared by a pop, a later restore can still reach them
    always_ff @(posedge clk) begin
        if (push && !restore) begin
            stack[pushSlot] <= pushAddr;
        end
    end

    // One fetch block holds either a call or a return, never both
    pushPopExclusive: assert property (
        @(posedge clk) disable iff (rst)
        !(push && pop)
    );

endmodule

`default_nettype wire

//--- logic/updateQueue.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module updateQueue (
    input  wire                    clk,
    input  wire                    rst,
    input  wire                    enq,
    input  wire [`BP_FID_W-1:0]    enqId,
    input  wire                    enqTaken,
    input  wire                    deq,
    output logic                   headValid,
    output logic [`BP_FID_W-1:0]   headId,
    output logic                   headTaken
);

    localparam int PTR_W = $clog2(`BP_UPDQ_DEPTH);
    localparam int CNT_W = $clog2(`BP_UPDQ_DEPTH + 1);

    logic [`BP_FID_W-1:0] idMem    [`BP_UPDQ_DEPTH];
    logic                 takenMem [`BP_UPDQ_DEPTH];

    logic [PTR_W-1:0] rdPtr;
    logic [PTR_W-1:0] wrPtr;
    logic [CNT_W-1:0] count;
    logic             doDeq;

    assign headValid = (count != '0);
    assign headId    = idMem[rdPtr];
    assign headTaken = takenMem[rdPtr];
    assign doDeq     = deq && headValid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (enq) begin
                wrPtr <= wrPtr + 1'b1;
            end
            if (doDeq) begin
                rdPtr <= rdPtr + 1'b1;
            end
            case ({enq, doDeq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (enq) begin
            idMem[wrPtr]    <= enqId;
            takenMem[wrPtr] <= enqTaken;
        end
    end

    // No ready output, commit must never outrun the drain
    noOverflow: assert property (
        @(posedge clk) disable iff (rst)
        (enq && count == CNT_W'(`BP_UPDQ_DEPTH)) |-> deq
    );

endmodule

`default_nettype wire

//--- logic/branchPredictor.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module branchPredictor (
    input  wire                        clk,
    input  wire                        rst,
    input  wire                        fetchValid,
    input  wire [`BP_FID_W-1:0]        fetchId,
    output logic [`BP_PC_W-1:0]        pc,
    output logic                       predValid,
    output bpredPkg::BranchType        predType,
    output logic                       predTaken,
    output logic [`BP_OFF_W-1:0]       predOffs,
    output logic [`BP_PC_W-1:0]        predDst,
    input  wire                        misprValid,
    input  wire [`BP_FID_W-1:0]        misprId,
    input  wire [`BP_PC_W-1:0]         misprDst,
    input  wire                        misprTaken,
    input  wire                        misprIsBranch,
    input  bpredPkg::RetAction         misprRetAct,
    input  wire                        btUpdValid,
    input  wire [`BP_PC_W-1:0]         btUpdPc,
    input  wire [`BP_PC_W-1:0]         btUpdDst,
    input  bpredPkg::BranchType        btUpdType,
    input  wire                        commitValid,
    input  wire [`BP_FID_W-1:0]        commitId,
    input  wire                        commitTaken,
    output logic                       fetchLimitValid,
    output logic [`BP_FID_W-1:0]       fetchLimitId
);

    localparam int BK_ENTRIES = 1 << `BP_FID_W;

    btbUpdateIf btbUpd ();
    dirUpdateIf dirUpd ();

    bpredPkg::PredBranch btbHit;
    bpredPkg::PredBranch pred;
    bpredPkg::BpBackup   bkFile [BK_ENTRIES];
    bpredPkg::BpBackup   bkWr;
    bpredPkg::BpBackup   bkRd;

    logic [`BP_HIST_W-1:0]    history;
    logic [`BP_HIST_W-1:0]    fetchHistory;
    logic [`BP_HIST_W-1:0]    recHistory;
    logic [`BP_RAS_IDX_W-1:0] recRIdx;
    logic [`BP_RAS_IDX_W-1:0] rasIdx;
    logic [`BP_PC_W-1:0]      rasTop;
    logic [`BP_PC_W-1:0]      nextPc;
    logic [`BP_FID_W-1:0]     bkRdAddr;
    logic                     dirTaken;
    logic                     fetchGo;
    logic                     rasPush;
    logic                     rasPop;

    logic                     qHeadValid;
    logic [`BP_FID_W-1:0]     qHeadId;
    logic                     qHeadTaken;
    logic                     qDeq;

    logic                     updValid;
    logic [`BP_PC_W-1:0]      updPc;
    logic [`BP_HIST_W-1:0]    updHistory;
    logic                     updTaken;

    assign btbUpd.valid = btUpdValid;
    assign btbUpd.pc    = btUpdPc;
    assign btbUpd.dst   = btUpdDst;
    assign btbUpd.btype = btUpdType;

    branchTargetBuffer btb_i (
        .clk (clk),
        .rst (rst),
        .pc  (pc),
        .upd (btbUpd),
        .hit (btbHit)
    );

    directionPredictor dir_i (
        .clk     (clk),
        .rst     (rst),
        .pc      (pc),
        .history (history),
        .taken   (dirTaken),
        .upd     (dirUpd)
    );

    returnStack ras_i (
        .clk        (clk),
        .rst        (rst),
        .push       (rasPush),
        .pop        (rasPop),
        .pushAddr   ({pc[`BP_PC_W-1:`BP_OFF_W], pred.offs} + 1'b1),
        .restore    (misprValid),
        .restoreIdx (recRIdx),
        .topAddr    (rasTop),
        .idx        (rasIdx)
    );

    // Prediction select
    always_comb begin
        pred = btbHit;
        if (btbHit.valid && btbHit.btype == bpredPkg::BT_RETURN) begin
            pred.dst = rasTop;
        end else if (btbHit.valid && btbHit.btype == bpredPkg::BT_BRANCH) begin
            pred.taken = dirTaken;
        end else if (!btbHit.valid) begin
            // Direction only, no target known
            pred.btype = bpredPkg::BT_BRANCH;
            pred.taken = dirTaken;
            pred.offs  = '1;
        end
    end

    assign predValid = pred.valid;
    assign predType  = pred.btype;
    assign predTaken = pred.taken;
    assign predOffs  = pred.offs;
    assign predDst   = pred.dst;

    assign fetchGo = fetchValid && !misprValid;
    assign rasPush = fetchGo && pred.valid && pred.btype == bpredPkg::BT_CALL;
    assign rasPop  = fetchGo && pred.valid && pred.btype == bpredPkg::BT_RETURN;

    assign nextPc = (pred.valid && pred.taken) ? pred.dst
                  : {pc[`BP_PC_W-1:`BP_OFF_W] + 1'b1, {`BP_OFF_W{1'b0}}};

    assign fetchHistory = (pred.valid && pred.btype == bpredPkg::BT_BRANCH)
                        ? {history[`BP_HIST_W-2:0], pred.taken} : history;

    // Backup file, written at fetch and read for recovery or training
    always_comb begin
        bkWr.fetchPc   = pc;
        bkWr.history   = history;
        bkWr.rIdx      = rasIdx;
        bkWr.pred      = pred.valid;
        bkWr.predTaken = pred.taken;
        bkWr.predOffs  = pred.offs;
    end

    always_ff @(posedge clk) begin
        if (fetchGo) begin
            bkFile[fetchId] <= bkWr;
        end
    end

    // Mispredict wins the single read port
    assign bkRdAddr = misprValid ? misprId : qHeadId;
    assign bkRd = bkFile[bkRdAddr];

    assign recHistory = misprIsBranch ? {bkRd.history[`BP_HIST_W-2:0], misprTaken}
                      : bkRd.history;

    always_comb begin
        recRIdx = bkRd.rIdx;
        case (misprRetAct)
            bpredPkg::RET_PUSH: recRIdx = bkRd.rIdx + 1'b1;
            bpredPkg::RET_POP:  recRIdx = bkRd.rIdx - 1'b1;
            default:            recRIdx = bkRd.rIdx;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc      <= `BP_ENTRY_POINT;
            history <= '0;
        end else if (misprValid) begin
            pc      <= misprDst;
            history <= recHistory;
        end else if (fetchValid) begin
            pc      <= nextPc;
            history <= fetchHistory;
        end
    end

    updateQueue updq_i (
        .clk       (clk),
        .rst       (rst),
        .enq       (commitValid),
        .enqId     (commitId),
        .enqTaken  (commitTaken),
        .deq       (qDeq),
        .headValid (qHeadValid),
        .headId    (qHeadId),
        .headTaken (qHeadTaken)
    );

    assign qDeq = qHeadValid && !misprValid;

    // Training stage, one cycle behind the pop
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            updValid <= 1'b0;
        end else begin
            updValid <= qDeq;
        end
    end

    always_ff @(posedge clk) begin
        if (qDeq) begin
            updPc      <= bkRd.fetchPc;
            updHistory <= bkRd.history;
            updTaken   <= qHeadTaken;
        end
    end

    assign dirUpd.valid   = updValid;
    assign dirUpd.pc      = updPc;
    assign dirUpd.history = updHistory;
    assign dirUpd.taken   = updTaken;

    // Oldest fetch ID whose backup entry is still needed
    assign fetchLimitValid = qHeadValid || commitValid;
    assign fetchLimitId    = qHeadValid ? qHeadId : commitId;

endmodule

`default_nettype wire

//--- bench/bpChecker.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module bpChecker (
    input  wire                        clk,
    input  wire                        rst,
    input  wire [127:0]                testName,
    input  wire                        fetchValid,
    input  wire [`BP_FID_W-1:0]        fetchId,
    input  wire [`BP_PC_W-1:0]         pc,
    input  wire                        predValid,
    input  bpredPkg::BranchType        predType,
    input  wire                        predTaken,
    input  wire [`BP_OFF_W-1:0]        predOffs,
    input  wire [`BP_PC_W-1:0]         predDst,
    input  wire                        misprValid,
    input  wire [`BP_FID_W-1:0]        misprId,
    input  wire [`BP_PC_W-1:0]         misprDst,
    input  wire                        misprTaken,
    input  wire                        misprIsBranch,
    input  bpredPkg::RetAction         misprRetAct,
    input  wire                        btUpdValid,
    input  wire [`BP_PC_W-1:0]         btUpdPc,
    input  wire [`BP_PC_W-1:0]         btUpdDst,
    input  bpredPkg::BranchType        btUpdType,
    input  wire                        commitValid,
    input  wire [`BP_FID_W-1:0]        commitId,
    input  wire                        commitTaken,
    input  wire                        fetchLimitValid,
    input  wire [`BP_FID_W-1:0]        fetchLimitId,
    output int                         errors
);

    localparam int BTB_N = 1 << `BP_BTB_IDX_W;
    localparam int PHT_N = 1 << `BP_PHT_IDX_W;
    localparam int RAS_N = 1 << `BP_RAS_IDX_W;
    localparam int BK_N  = 1 << `BP_FID_W;

    // Reference state
    logic [`BP_PC_W-1:0]       mPc;
    logic [`BP_HIST_W-1:0]     mHist;
    logic [1:0]                mPht [PHT_N];
    logic                      mBtbValid [BTB_N];
    logic [`BP_PC_W-1:0]       mBtbPc [BTB_N];
    logic [`BP_PC_W-1:0]       mBtbDst [BTB_N];
    bpredPkg::BranchType       mBtbType [BTB_N];
    logic [`BP_PC_W-1:0]       mRas [RAS_N];
    logic [`BP_RAS_IDX_W-1:0]  mRasIdx;
    logic [`BP_PC_W-1:0]       bkPc [BK_N];
    logic [`BP_HIST_W-1:0]     bkHist [BK_N];
    logic [`BP_RAS_IDX_W-1:0]  bkRIdx [BK_N];
    logic [`BP_FID_W:0]        pending [$];
    logic                      trainValid;
    logic [`BP_PHT_IDX_W-1:0]  trainIdx;
    logic                      trainTaken;

    // Expected prediction of the current cycle
    logic [`BP_BTB_IDX_W-1:0]  eIdx;
    logic                      eHit;
    bpredPkg::BranchType       eType;
    logic                      eTaken;
    logic [`BP_OFF_W-1:0]      eOffs;
    logic [`BP_PC_W-1:0]       eDst;
    logic [`BP_FID_W:0]        head;
    logic [`BP_FID_W-1:0]      hid;

    initial errors = 0;

    task automatic compare(input string sig, input logic [31:0] expVal,
                           input logic [31:0] actVal);
        if (actVal !== expVal) begin
            errors++;
            $display("Error %0s %0s: expected %h, actual %h", testName, sig, expVal, actVal);
        end
    endtask

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            mPc = `BP_ENTRY_POINT;
            mHist = '0;
            mRasIdx = '0;
            trainValid = 1'b0;
            pending.delete();
            for (int i = 0; i < PHT_N; i++) begin
                mPht[i] = 2'b01;
            end
            for (int i = 0; i < BTB_N; i++) begin
                mBtbValid[i] = 1'b0;
            end
        end else begin
            // Same block address and the branch not behind the fetch offset
            eIdx = mPc[`BP_OFF_W +: `BP_BTB_IDX_W];
            eHit = mBtbValid[eIdx]
                && (mBtbPc[eIdx] >> `BP_OFF_W) == (mPc >> `BP_OFF_W)
                && mBtbPc[eIdx][`BP_OFF_W-1:0] >= mPc[`BP_OFF_W-1:0];
            eType = mBtbType[eIdx];
            eOffs = mBtbPc[eIdx][`BP_OFF_W-1:0];
            eDst = (eType == bpredPkg::BT_RETURN) ? mRas[mRasIdx] : mBtbDst[eIdx];
            eTaken = mPht[mPc[`BP_OFF_W +: `BP_PHT_IDX_W] ^ mHist][1];
            if (eHit && eType != bpredPkg::BT_BRANCH) begin
                eTaken = 1'b1;
            end

            compare("pc", mPc, pc);
            compare("predValid", eHit, predValid);
            compare("predTaken", eTaken, predTaken);
            if (eHit) begin
                compare("predType", eType, predType);
                compare("predOffs", eOffs, predOffs);
                compare("predDst", eDst, predDst);
            end
            compare("fetchLimitValid", pending.size() != 0 || commitValid, fetchLimitValid);
            if (pending.size() != 0) begin
                compare("fetchLimitId", pending[0][`BP_FID_W:1], fetchLimitId);
            end else if (commitValid) begin
                compare("fetchLimitId", commitId, fetchLimitId);
            end

            // Training write registered from the previous pop
            if (trainValid) begin
                if (trainTaken && mPht[trainIdx] != 2'b11) begin
                    mPht[trainIdx] = mPht[trainIdx] + 2'b01;
                end else if (!trainTaken && mPht[trainIdx] != 2'b00) begin
                    mPht[trainIdx] = mPht[trainIdx] - 2'b01;
                end
            end
            trainValid = 1'b0;
            if (pending.size() != 0 && !misprValid) begin
                head = pending.pop_front();
                hid = head[`BP_FID_W:1];
                trainValid = 1'b1;
                trainIdx = bkPc[hid][`BP_OFF_W +: `BP_PHT_IDX_W] ^ bkHist[hid];
                trainTaken = head[0];
            end

            if (misprValid) begin
                mPc = misprDst;
                mHist = misprIsBranch ? {bkHist[misprId][`BP_HIST_W-2:0], misprTaken}
                      : bkHist[misprId];
                mRasIdx = bkRIdx[misprId];
                if (misprRetAct == bpredPkg::RET_PUSH) begin
                    mRasIdx = mRasIdx + 1'b1;
                end else if (misprRetAct == bpredPkg::RET_POP) begin
                    mRasIdx = mRasIdx - 1'b1;
                end
            end else if (fetchValid) begin
                bkPc[fetchId] = mPc;
                bkHist[fetchId] = mHist;
                bkRIdx[fetchId] = mRasIdx;
                if (eHit && eType == bpredPkg::BT_CALL) begin
                    mRasIdx = mRasIdx + 1'b1;
                    mRas[mRasIdx] = (mPc & ~31'h3) + eOffs + 31'd1;
                end else if (eHit && eType == bpredPkg::BT_RETURN) begin
                    mRasIdx = mRasIdx - 1'b1;
                end
                if (eHit && eType == bpredPkg::BT_BRANCH) begin
                    mHist = {mHist[`BP_HIST_W-2:0], eTaken};
                end
                mPc = (eHit && eTaken) ? eDst : (mPc & ~31'h3) + 31'd4;
            end

            if (btUpdValid) begin
                mBtbValid[btUpdPc[`BP_OFF_W +: `BP_BTB_IDX_W]] = 1'b1;
                mBtbPc[btUpdPc[`BP_OFF_W +: `BP_BTB_IDX_W]] = btUpdPc;
                mBtbDst[btUpdPc[`BP_OFF_W +: `BP_BTB_IDX_W]] = btUpdDst;
                mBtbType[btUpdPc[`BP_OFF_W +: `BP_BTB_IDX_W]] = btUpdType;
            end
            if (commitValid) begin
                pending.push_back({commitId, commitTaken});
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/branchPredictorTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpred_cfg.svh"

module branchPredictorTb;

    typedef struct packed {
        logic [127:0]               name;
        logic                       fetch;
        logic [`BP_FID_W-1:0]       fid;
        logic                       mispr;
        logic [`BP_FID_W-1:0]       mid;
        logic [`BP_PC_W-1:0]        mdst;
        logic                       misBr;
        logic                       mTaken;
        bpredPkg::RetAction         mret;
        logic                       bt;
        logic [`BP_PC_W-1:0]        btPc;
        logic [`BP_PC_W-1:0]        btDst;
        bpredPkg::BranchType        btType;
        logic                       commit;
        logic [`BP_FID_W-1:0]       cid;
        logic                       cTaken;
        logic                       cRand;
        logic                       drain;
        logic [`BP_PC_W-1:0]        expPc;
    } StimRow;

    logic                   clk;
    logic                   rst;
    logic [127:0]           testName;
    logic                   fetchValid;
    logic [`BP_FID_W-1:0]   fetchId;
    logic [`BP_PC_W-1:0]    pc;
    logic                   predValid;
    bpredPkg::BranchType    predType;
    logic                   predTaken;
    logic [`BP_OFF_W-1:0]   predOffs;
    logic [`BP_PC_W-1:0]    predDst;
    logic                   misprValid;
    logic [`BP_FID_W-1:0]   misprId;
    logic [`BP_PC_W-1:0]    misprDst;
    logic                   misprTaken;
    logic                   misprIsBranch;
    bpredPkg::RetAction     misprRetAct;
    logic                   btUpdValid;
    logic [`BP_PC_W-1:0]    btUpdPc;
    logic [`BP_PC_W-1:0]    btUpdDst;
    bpredPkg::BranchType    btUpdType;
    logic                   commitValid;
    logic [`BP_FID_W-1:0]   commitId;
    logic                   commitTaken;
    logic                   fetchLimitValid;
    logic [`BP_FID_W-1:0]   fetchLimitId;
    int                     errors;

    StimRow rows [$];
    int     seed = 42;
    int     tableErrors = 0;
    int     timeouts = 0;

    branchPredictor dut_i (.*);
    bpChecker chk_i (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic StimRow blankRow(input logic [127:0] name, input logic [30:0] expPc);
        StimRow r;
        r = '0;
        r.name = name;
        r.expPc = expPc;
        r.mret = bpredPkg::RET_NONE;
        r.btType = bpredPkg::BT_BRANCH;
        return r;
    endfunction

    task automatic addIdle(input logic [127:0] name, input logic [30:0] expPc);
        rows.push_back(blankRow(name, expPc));
    endtask

    task automatic addFetch(input logic [127:0] name, input int id, input logic [30:0] expPc);
        StimRow r;
        r = blankRow(name, expPc);
        r.fetch = 1'b1;
        r.fid = id;
        rows.push_back(r);
    endtask

    task automatic addBtb(input logic [127:0] name, input logic [30:0] bPc,
                          input logic [30:0] dst, input bpredPkg::BranchType t,
                          input logic [30:0] expPc);
        StimRow r;
        r = blankRow(name, expPc);
        r.bt = 1'b1;
        r.btPc = bPc;
        r.btDst = dst;
        r.btType = t;
        rows.push_back(r);
    endtask

    task automatic addMisprRet(input logic [127:0] name, input int id, input logic [30:0] dst,
                               input logic isBr, input logic taken,
                               input bpredPkg::RetAction ret, input logic [30:0] expPc);
        StimRow r;
        r = blankRow(name, expPc);
        r.mispr = 1'b1;
        r.mid = id;
        r.mdst = dst;
        r.misBr = isBr;
        r.mTaken = taken;
        r.mret = ret;
        rows.push_back(r);
    endtask

    task automatic addMispr(input logic [127:0] name, input int id, input logic [30:0] dst,
                            input logic isBr, input logic taken, input logic [30:0] expPc);
        addMisprRet(name, id, dst, isBr, taken, bpredPkg::RET_NONE, expPc);
    endtask

    task automatic addCommit(input logic [127:0] name, input int id, input logic taken,
                             input logic useRand, input logic drain, input logic [30:0] expPc);
        StimRow r;
        r = blankRow(name, expPc);
        r.commit = 1'b1;
        r.cid = id;
        r.cTaken = taken;
        r.cRand = useRand;
        r.drain = drain;
        rows.push_back(r);
    endtask

    task automatic driveRow(input StimRow r);
        fetchValid = r.fetch;
        fetchId = r.fid;
        misprValid = r.mispr;
        misprId = r.mid;
        misprDst = r.mdst;
        misprTaken = r.mTaken;
        misprIsBranch = r.misBr;
        misprRetAct = r.mret;
        btUpdValid = r.bt;
        btUpdPc = r.btPc;
        btUpdDst = r.btDst;
        btUpdType = r.btType;
        commitValid = r.commit;
        commitId = r.cid;
        commitTaken = r.cRand ? ($random(seed) % 2 != 0) : r.cTaken;
    endtask

    task automatic waitDrain();
        int cycles;
        cycles = 0;
        while (fetchLimitValid && cycles < 20) begin
            @(negedge clk);
            cycles++;
        end
        if (fetchLimitValid) begin
            timeouts++;
            $display("Timeout: fetchLimitValid stayed high after the update queue should drain");
        end
    endtask

    initial begin
        rst = 1'b1;
        testName = "reset";
        driveRow(blankRow("reset", '0));

        // Sequential blocks, then a jump
        addFetch("seqFetch0", 0, 31'h100);
        addFetch("seqFetch1", 1, 31'h104);
        addFetch("seqFetch2", 2, 31'h108);
        addBtb("jumpUpd", 31'h111, 31'h200, bpredPkg::BT_JUMP, 31'h10C);
        addFetch("seqFetch3", 3, 31'h10C);
        addFetch("jumpFetch", 4, 31'h110);
        // Call into 0x300, return from 0x305
        addBtb("callUpd", 31'h202, 31'h300, bpredPkg::BT_CALL, 31'h200);
        addBtb("retUpd", 31'h305, 31'h0, bpredPkg::BT_RETURN, 31'h200);
        addFetch("callFetch", 5, 31'h200);
        addFetch("calleeFetch", 6, 31'h300);
        addFetch("retFetch", 7, 31'h304);
        addFetch("afterRet", 0, 31'h203);
        // Conditional branch trained to taken
        addBtb("brUpd", 31'h409, 31'h500, bpredPkg::BT_BRANCH, 31'h204);
        addMispr("toBranch", 0, 31'h408, 1'b0, 1'b0, 31'h204);
        addFetch("brNotTaken", 1, 31'h408);
        addCommit("commitTaken0", 1, 1'b1, 1'b0, 1'b0, 31'h40C);
        addCommit("commitTaken1", 1, 1'b1, 1'b0, 1'b1, 31'h40C);
        addIdle("trainSettle0", 31'h40C);
        addIdle("trainSettle1", 31'h40C);
        addMispr("backToBranch", 1, 31'h408, 1'b0, 1'b0, 31'h40C);
        addFetch("brTaken", 2, 31'h408);
        // Recovery of history and return index
        addMispr("misprNotTaken", 2, 31'h40C, 1'b1, 1'b0, 31'h500);
        addMispr("misprTakenHist", 2, 31'h408, 1'b1, 1'b1, 31'h40C);
        addFetch("brRestoredHist", 3, 31'h408);
        addMispr("restoreRas", 7, 31'h304, 1'b0, 1'b0, 31'h40C);
        addFetch("retAfterRestore", 4, 31'h304);
        // Call snapshot taken before its push, recovery re-applies it
        addMisprRet("misprCallPush", 5, 31'h304, 1'b0, 1'b0, bpredPkg::RET_PUSH, 31'h203);
        addFetch("retAfterPush", 6, 31'h304);
        // Random commit outcomes
        addCommit("commitRand0", 3, 1'b0, 1'b1, 1'b0, 31'h203);
        addCommit("commitRand1", 4, 1'b0, 1'b1, 1'b1, 31'h203);
        addIdle("randSettle", 31'h203);
        addFetch("finalFetch", 5, 31'h203);
        addIdle("finalIdle", 31'h204);

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            @(negedge clk);
            testName = rows[i].name;
            if (pc !== rows[i].expPc) begin
                tableErrors++;
                $display("Error %0s: expected pc %h, actual %h", rows[i].name, rows[i].expPc, pc);
            end
            driveRow(rows[i]);
            if (rows[i].drain) begin
                @(negedge clk);
                driveRow(blankRow(rows[i].name, '0));
                waitDrain();
            end
        end
        @(negedge clk);
        driveRow(blankRow("end", '0));
        repeat (2) @(negedge clk);

        $display("Error counts: checker %0d, table %0d, timeouts %0d",
                 errors, tableErrors, timeouts);
        if (errors == 0 && tableErrors == 0 && timeouts == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+include
logic/bpredPkg.sv
logic/bpredIfs.sv
logic/branchTargetBuffer.sv
logic/directionPredictor.sv
logic/returnStack.sv
logic/updateQueue.sv
logic/branchPredictor.sv
bench/bpChecker.sv
bench/branchPredictorTb.sv
